/* src.f */
+incdir+.
ext_mem_pkg.sv
l1_cache.sv
bus_merge.sv
axi_mem_bridge.sv
ext_mem.sv
ext_mem_properties.sv
ext_mem_tb.sv

/* Bender.yml */
package:
  name: ext_mem

sources:
  - include_dirs:
      - .
    files:
      - ext_mem_pkg.sv
      - l1_cache.sv
      - bus_merge.sv
      - axi_mem_bridge.sv
      - ext_mem.sv
  - target: test
    include_dirs:
      - .
    files:
      - ext_mem_properties.sv
      - ext_mem_tb.sv

/* ext_mem_tb.sv */
`timescale 1ns/1ps

`include "ext_mem_defs.svh"

module ext_mem_tb
   import ext_mem_pkg::*;
();

   localparam int BYTE_OFF_W = $clog2(`EXT_MEM_DATA_W / 8);
   localparam int MEM_WORDS  = 1 << (`EXT_MEM_MEM_ADDR_W - BYTE_OFF_W);
   localparam int TIMEOUT    = 200;

   logic         clk;
   logic         reset;
   mem_req_t     i_req;
   mem_resp_t    i_resp;
   mem_req_t     d_req;
   mem_resp_t    d_resp;
   cache_stats_t i_stats;
   cache_stats_t d_stats;
   axi_req_t     axi_out;
   axi_resp_t    axi_in;

   // Model memory and the expected copy kept by the tests
   data_t mem [MEM_WORDS];
   data_t ref_mem [MEM_WORDS];
   int    errors;
   int    timeouts;
   cnt_t  exp_i_hits;
   cnt_t  exp_i_misses;
   cnt_t  exp_d_hits;
   cnt_t  exp_d_misses;

   // AXI model state
   axi_req_t  bus_q;
   axi_resp_t rsp_q;
   int        ar_cnt;
   int        r_cnt;
   int        aw_cnt;
   int        w_cnt;
   int        b_cnt;
   bit        r_pend;
   bit        aw_got;
   bit        w_got;
   bit        b_pend;
   int        r_idx;
   int        w_idx;
   data_t     w_data;
   strb_t     w_strb;

   ext_mem DUT (
      .clk     (clk),
      .reset   (reset),
      .i_req   (i_req),
      .i_resp  (i_resp),
      .d_req   (d_req),
      .d_resp  (d_resp),
      .i_stats (i_stats),
      .d_stats (d_stats),
      .axi_out (axi_out),
      .axi_in  (axi_in)
   );

   always #10 clk = ~clk;

   function automatic int word_idx(input addr_t addr);
      return int'(addr[`EXT_MEM_MEM_ADDR_W-1:BYTE_OFF_W]);
   endfunction

   // AXI slave judges handshakes mid-cycle and answers 1 ns after the edge
   always begin
      @(negedge clk);
      bus_q = axi_out;
      rsp_q = axi_in;
      @(posedge clk);
      #1;
      if (!reset) begin
         if (bus_q.arvalid && rsp_q.arready) begin
            axi_in.arready = 1'b0;
            r_idx  = word_idx(bus_q.araddr);
            r_pend = 1'b1;
            ar_cnt = $urandom_range(3);
            r_cnt  = $urandom_range(3);
         end else if (bus_q.arvalid) begin
            if (ar_cnt == 0) begin
               axi_in.arready = 1'b1;
            end else begin
               ar_cnt--;
            end
         end
         if (bus_q.rready && rsp_q.rvalid) begin
            axi_in.rvalid = 1'b0;
         end else if (r_pend) begin
            if (r_cnt == 0) begin
               axi_in.rvalid = 1'b1;
               axi_in.rdata  = mem[r_idx];
               r_pend = 1'b0;
            end else begin
               r_cnt--;
            end
         end
         if (bus_q.awvalid && rsp_q.awready) begin
            axi_in.awready = 1'b0;
            w_idx  = word_idx(bus_q.awaddr);
            aw_got = 1'b1;
            aw_cnt = $urandom_range(3);
         end else if (bus_q.awvalid) begin
            if (aw_cnt == 0) begin
               axi_in.awready = 1'b1;
            end else begin
               aw_cnt--;
            end
         end
         if (bus_q.wvalid && rsp_q.wready) begin
            axi_in.wready = 1'b0;
            w_data = bus_q.wdata;
            w_strb = bus_q.wstrb;
            w_got  = 1'b1;
            w_cnt  = $urandom_range(3);
         end else if (bus_q.wvalid) begin
            if (w_cnt == 0) begin
               axi_in.wready = 1'b1;
            end else begin
               w_cnt--;
            end
         end
         // Commit once both halves of the write are in, then schedule the response
         if (aw_got && w_got) begin
            for (int b = 0; b < `EXT_MEM_DATA_W / 8; b++) begin
               if (w_strb[b]) begin
                  mem[w_idx][8*b +: 8] = w_data[8*b +: 8];
               end
            end
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_pend = 1'b1;
            b_cnt  = $urandom_range(3);
         end
         if (bus_q.bready && rsp_q.bvalid) begin
            axi_in.bvalid = 1'b0;
         end else if (b_pend) begin
            if (b_cnt == 0) begin
               axi_in.bvalid = 1'b1;
               b_pend = 1'b0;
            end else begin
               b_cnt--;
            end
         end
      end
   end

   task automatic check_value(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
         errors++;
      end
   endtask

   // One native transfer that starts and ends 1 ns after a rising edge
   task automatic access(input bit is_d, input addr_t addr, input data_t wdata,
                         input strb_t wstrb, output data_t rdata, output int cycles);
      mem_req_t req;
      logic     ready;
      req.valid = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      if (is_d) begin
         d_req = req;
      end else begin
         i_req = req;
      end
      cycles = 0;
      ready  = 1'b0;
      while (!ready && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         ready = is_d ? d_resp.ready : i_resp.ready;
         rdata = is_d ? d_resp.rdata : i_resp.rdata;
      end
      if (!ready) begin
         $display("Timeout: %s port got no ready for address 0x%h",
                  is_d ? "data" : "instruction", addr);
         timeouts++;
      end
      @(posedge clk);
      #1;
      if (is_d) begin
         d_req = '0;
      end else begin
         i_req = '0;
      end
   endtask

   // A hit answers in the cycle after valid is first sampled
   task automatic read_check(input bit is_d, input addr_t addr, input data_t exp_word,
                             input bit exp_hit);
      data_t rdata;
      int    cycles;
      access(is_d, addr, '0, '0, rdata, cycles);
      check_value(is_d ? "d_resp.rdata" : "i_resp.rdata", rdata, exp_word);
      if (exp_hit) begin
         check_value("read hit latency", cycles, 2);
      end
      if (is_d && exp_hit) begin
         exp_d_hits++;
      end else if (is_d) begin
         exp_d_misses++;
      end else if (exp_hit) begin
         exp_i_hits++;
      end else begin
         exp_i_misses++;
      end
   endtask

   task automatic write_data(input addr_t addr, input data_t wdata, input strb_t wstrb);
      data_t rdata;
      int    cycles;
      int    wi;
      wi = word_idx(addr);
      for (int b = 0; b < `EXT_MEM_DATA_W / 8; b++) begin
         if (wstrb[b]) begin
            ref_mem[wi][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      access(1'b1, addr, wdata, wstrb, rdata, cycles);
      check_value("model memory word", mem[wi], ref_mem[wi]);
   endtask

   task automatic check_counters();
      check_value("i_stats.hits", i_stats.hits, exp_i_hits);
      check_value("i_stats.misses", i_stats.misses, exp_i_misses);
      check_value("d_stats.hits", d_stats.hits, exp_d_hits);
      check_value("d_stats.misses", d_stats.misses, exp_d_misses);
   endtask

   task automatic test_reset();
      check_value("i_resp.ready", i_resp.ready, 0);
      check_value("d_resp.ready", d_resp.ready, 0);
      check_value("axi_out.arvalid", axi_out.arvalid, 0);
      check_value("axi_out.awvalid", axi_out.awvalid, 0);
      check_value("axi_out.wvalid", axi_out.wvalid, 0);
      check_value("axi_out.bready", axi_out.bready, 0);
      check_value("axi_out.rready", axi_out.rready, 0);
      check_counters();
   endtask

   task automatic test_data_read();
      addr_t a;
      a = 32'h0000_0100;
      read_check(1'b1, a, ref_mem[word_idx(a)], 1'b0);
      read_check(1'b1, a, ref_mem[word_idx(a)], 1'b1);
      check_counters();
   endtask

   task automatic test_partial_write();
      addr_t a;
      addr_t b;
      a = 32'h0000_0100;
      b = 32'h0000_0204;
      // Cached line gets patched
      write_data(a, 32'ha1b2_c3d4, 4'b0101);
      read_check(1'b1, a, ref_mem[word_idx(a)], 1'b1);
      // No write allocate, so the merged word comes back from memory
      write_data(b, 32'h5566_7788, 4'b1010);
      read_check(1'b1, b, ref_mem[word_idx(b)], 1'b0);
      check_counters();
   endtask

   task automatic test_ifetch();
      addr_t a;
      data_t old_word;
      a = 32'h0000_0400;
      old_word = ref_mem[word_idx(a)];
      read_check(1'b0, a, old_word, 1'b0);
      read_check(1'b0, a, old_word, 1'b1);
      write_data(a, ~old_word, 4'b1111);
      // Instruction cache keeps the stale word
      read_check(1'b0, a, old_word, 1'b1);
      read_check(1'b1, a, ref_mem[word_idx(a)], 1'b0);
      check_counters();
   endtask

   task automatic test_evict();
      addr_t x;
      addr_t y;
      // Same dcache index 17 with different tags
      x = 32'h0000_0844;
      y = 32'h0000_08c4;
      read_check(1'b1, x, ref_mem[word_idx(x)], 1'b0);
      read_check(1'b1, y, ref_mem[word_idx(y)], 1'b0);
      read_check(1'b1, x, ref_mem[word_idx(x)], 1'b0);
      read_check(1'b1, x, ref_mem[word_idx(x)], 1'b1);
      read_check(1'b1, y, ref_mem[word_idx(y)], 1'b0);
      check_counters();
   endtask

   task automatic test_concurrent();
      addr_t ia;
      addr_t da;
      for (int pass = 0; pass < 2; pass++) begin
         for (int k = 0; k < 8; k++) begin
            ia = 32'h0000_3000 + 4 * k;
            da = 32'h0000_5000 + 4 * k;
            fork
               read_check(1'b0, ia, ref_mem[word_idx(ia)], pass == 1);
               read_check(1'b1, da, ref_mem[word_idx(da)], pass == 1);
            join
         end
      end
      check_counters();
   endtask

   initial begin
      void'($urandom(51));
      clk   = 1'b0;
      reset = 1'b1;
      i_req = '0;
      d_req = '0;
      axi_in = '0;
      errors = 0;
      timeouts = 0;
      exp_i_hits = '0;
      exp_i_misses = '0;
      exp_d_hits = '0;
      exp_d_misses = '0;
      {r_pend, aw_got, w_got, b_pend} = '0;
      ar_cnt = $urandom_range(3);
      aw_cnt = $urandom_range(3);
      w_cnt  = $urandom_range(3);
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i]     = $urandom;
         ref_mem[i] = mem[i];
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset();
      test_data_read();
      test_partial_write();
      test_ifetch();
      test_evict();
      test_concurrent();
      $display("Run finished with %0d errors, %0d timeouts and %0d assertion failures",
               errors, timeouts, DUT.props.fail_cnt);
      if (errors == 0 && timeouts == 0 && DUT.props.fail_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* ext_mem_properties.sv */
`timescale 1ns/1ps

module ext_mem_props
   import ext_mem_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input mem_req_t  i_req,
   input mem_resp_t i_resp,
   input mem_req_t  d_req,
   input mem_resp_t d_resp,
   input axi_req_t  axi_out,
   input axi_resp_t axi_in
);

   // Number of failed assertions so far
   int fail_cnt = 0;

   // AXI valids stay up until accepted
   ar_hold: assert property (@(posedge clk) disable iff (reset)
      axi_out.arvalid && !axi_in.arready |=> axi_out.arvalid)
      else begin
         $error("arvalid dropped before arready");
         fail_cnt++;
      end
   aw_hold: assert property (@(posedge clk) disable iff (reset)
      axi_out.awvalid && !axi_in.awready |=> axi_out.awvalid)
      else begin
         $error("awvalid dropped before awready");
         fail_cnt++;
      end
   w_hold: assert property (@(posedge clk) disable iff (reset)
      axi_out.wvalid && !axi_in.wready |=> axi_out.wvalid)
      else begin
         $error("wvalid dropped before wready");
         fail_cnt++;
      end

   // Port ready only answers a live request
   i_ready_valid: assert property (@(posedge clk) disable iff (reset)
      i_resp.ready |-> i_req.valid)
      else begin
         $error("i_resp.ready without i_req.valid");
         fail_cnt++;
      end
   d_ready_valid: assert property (@(posedge clk) disable iff (reset)
      d_resp.ready |-> d_req.valid)
      else begin
         $error("d_resp.ready without d_req.valid");
         fail_cnt++;
      end

   ar_aw_apart: assert property (@(posedge clk) disable iff (reset)
      !(axi_out.arvalid && axi_out.awvalid))
      else begin
         $error("arvalid and awvalid high together");
         fail_cnt++;
      end

endmodule

bind ext_mem ext_mem_props props (
   .clk     (clk),
   .reset   (reset),
   .i_req   (i_req),
   .i_resp  (i_resp),
   .d_req   (d_req),
   .d_resp  (d_resp),
   .axi_out (axi_out),
   .axi_in  (axi_in)
);

/* ext_mem.sv */
`timescale 1ns/1ps

`include "ext_mem_defs.svh"

module ext_mem
   import ext_mem_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  mem_req_t     i_req,
   output mem_resp_t    i_resp,
   input  mem_req_t     d_req,
   output mem_resp_t    d_resp,
   output cache_stats_t i_stats,
   output cache_stats_t d_stats,
   output axi_req_t     axi_out,
   input  axi_resp_t    axi_in
);

   // Cache back ends, index 0 is data and 1 is instruction
   mem_req_t  [1:0] be_req;
   mem_resp_t [1:0] be_resp;

   // Merged bus into the bridge
   mem_req_t  mem_req;
   mem_resp_t mem_resp;

   l1_cache #(
      .LINE_OFF_W (`EXT_MEM_ICACHE_LINE_W)
   ) icache (
      .clk     (clk),
      .reset   (reset),
      .fe_req  (i_req),
      .fe_resp (i_resp),
      .be_req  (be_req[1]),
      .be_resp (be_resp[1]),
      .stats   (i_stats)
   );

   l1_cache #(
      .LINE_OFF_W (`EXT_MEM_DCACHE_LINE_W)
   ) dcache (
      .clk     (clk),
      .reset   (reset),
      .fe_req  (d_req),
      .fe_resp (d_resp),
      .be_req  (be_req[0]),
      .be_resp (be_resp[0]),
      .stats   (d_stats)
   );

   bus_merge merge_i_d (
      .clk    (clk),
      .reset  (reset),
      .m_req  (be_req),
      .m_resp (be_resp),
      .s_req  (mem_req),
      .s_resp (mem_resp)
   );

   axi_mem_bridge bridge (
      .clk     (clk),
      .reset   (reset),
      .req     (mem_req),
      .resp    (mem_resp),
      .axi_out (axi_out),
      .axi_in  (axi_in)
   );

endmodule

/* axi_mem_bridge.sv */
`timescale 1ns/1ps

`include "ext_mem_defs.svh"

module axi_mem_bridge
   import ext_mem_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  mem_req_t  req,
   output mem_resp_t resp,
   output axi_req_t  axi_out,
   input  axi_resp_t axi_in
);

   bridge_state_t state;
   logic          awvalid_q;
   logic          wvalid_q;
   logic          arvalid_q;
   logic          bready_q;
   logic          rready_q;
   mem_addr_t     addr_q;
   data_t         wdata_q;
   strb_t         wstrb_q;
   data_t         rdata_q;
   logic          aw_done;
   logic          w_done;

   // Each write channel finishes on its own handshake
   assign aw_done = !awvalid_q || axi_in.awready;
   assign w_done  = !wvalid_q || axi_in.wready;

   assign axi_out.awaddr  = addr_q;
   assign axi_out.awvalid = awvalid_q;
   assign axi_out.wdata   = wdata_q;
   assign axi_out.wstrb   = wstrb_q;
   assign axi_out.wvalid  = wvalid_q;
   assign axi_out.bready  = bready_q;
   assign axi_out.araddr  = addr_q;
   assign axi_out.arvalid = arvalid_q;
   assign axi_out.rready  = rready_q;

   assign resp.ready = (state == BR_DONE);
   assign resp.rdata = rdata_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= BR_IDLE;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         arvalid_q <= 1'b0;
         bready_q  <= 1'b0;
         rready_q  <= 1'b0;
      end else begin
         case (state)
            BR_IDLE: begin
               if (req.valid && (|req.wstrb)) begin
                  awvalid_q <= 1'b1;
                  wvalid_q  <= 1'b1;
                  state     <= BR_WRITE;
               end else if (req.valid) begin
                  arvalid_q <= 1'b1;
                  state     <= BR_READ;
               end
            end
            BR_WRITE: begin
               if (axi_in.awready) awvalid_q <= 1'b0;
               if (axi_in.wready) wvalid_q <= 1'b0;
               if (aw_done && w_done) begin
                  bready_q <= 1'b1;
                  state    <= BR_WRESP;
               end
            end
            // bresp and rresp carry nothing here
            BR_WRESP: begin
               if (axi_in.bvalid) begin
                  bready_q <= 1'b0;
                  state    <= BR_DONE;
               end
            end
            BR_READ: begin
               if (axi_in.arready) begin
                  arvalid_q <= 1'b0;
                  rready_q  <= 1'b1;
                  state     <= BR_RDATA;
               end
            end
            BR_RDATA: begin
               if (axi_in.rvalid) begin
                  rready_q <= 1'b0;
                  state    <= BR_DONE;
               end
            end
            default: state <= BR_IDLE;
         endcase
      end
   end

   // Request payload captured at acceptance, read word on the R handshake
   always_ff @(posedge clk) begin
      if ((state == BR_IDLE) && req.valid) begin
         addr_q  <= req.addr[`EXT_MEM_MEM_ADDR_W-1:0];
         wdata_q <= req.wdata;
         wstrb_q <= req.wstrb;
      end
      if ((state == BR_RDATA) && axi_in.rvalid) begin
         rdata_q <= axi_in.rdata;
      end
   end

endmodule

/* bus_merge.sv */
`timescale 1ns/1ps

`include "ext_mem_defs.svh"

module bus_merge
   import ext_mem_pkg::*;
(
   input  logic            clk,
   input  logic            reset,
   input  mem_req_t  [1:0] m_req,
   output mem_resp_t [1:0] m_resp,
   output mem_req_t        s_req,
   input  mem_resp_t       s_resp
);

   logic locked;
   logic grant_q;
   logic sel;

   // Master 0 wins whenever the bus is free and it is asking
   assign sel   = locked ? grant_q : !m_req[0].valid;
   assign s_req = m_req[sel];

   assign m_resp[0].rdata = s_resp.rdata;
   assign m_resp[0].ready = s_resp.ready && !sel;
   assign m_resp[1].rdata = s_resp.rdata;
   assign m_resp[1].ready = s_resp.ready && sel;

   // Grant held from the first valid cycle until the slave answers
   always_ff @(posedge clk) begin
      if (reset) begin
         locked  <= 1'b0;
         grant_q <= 1'b0;
      end else if (locked) begin
         if (s_resp.ready) begin
            locked <= 1'b0;
         end
      end else if (s_req.valid && !s_resp.ready) begin
         locked  <= 1'b1;
         grant_q <= sel;
      end
   end

endmodule

/* l1_cache.sv */
`timescale 1ns/1ps

`include "ext_mem_defs.svh"

module l1_cache
   import ext_mem_pkg::*;
#(
   parameter int LINE_OFF_W = 4
) (
   input  logic         clk,
   input  logic         reset,
   input  mem_req_t     fe_req,
   output mem_resp_t    fe_resp,
   output mem_req_t     be_req,
   input  mem_resp_t    be_resp,
   output cache_stats_t stats
);

   localparam int BYTE_OFF_W = $clog2(`EXT_MEM_DATA_W / 8);
   localparam int TAG_W      = `EXT_MEM_ADDR_W - LINE_OFF_W - BYTE_OFF_W;
   localparam int N_LINES    = 1 << LINE_OFF_W;

   cache_state_t          state;
   logic [TAG_W-1:0]      tag_arr [N_LINES];
   data_t                 data_arr [N_LINES];
   logic [N_LINES-1:0]    line_valid;
   logic [LINE_OFF_W-1:0] idx;
   logic [TAG_W-1:0]      tag;
   logic                  tag_hit;
   logic                  is_write;
   logic                  done_q;
   cnt_t                  hit_cnt;
   cnt_t                  miss_cnt;

   // Word index and tag straight from the held request
   assign idx      = fe_req.addr[BYTE_OFF_W +: LINE_OFF_W];
   assign tag      = fe_req.addr[`EXT_MEM_ADDR_W-1 -: TAG_W];
   assign tag_hit  = line_valid[idx] && (tag_arr[idx] == tag);
   assign is_write = |fe_req.wstrb;

   // A read hit answers in LOOKUP, everything else one cycle after the back end
   assign fe_resp.ready = done_q || ((state == CACHE_LOOKUP) && !is_write && tag_hit);
   // After a refill the line already holds the fetched word
   assign fe_resp.rdata = data_arr[idx];

   assign be_req.valid = (state == CACHE_REFILL) || (state == CACHE_WRITE);
   assign be_req.addr  = fe_req.addr;
   assign be_req.wdata = fe_req.wdata;
   assign be_req.wstrb = (state == CACHE_WRITE) ? fe_req.wstrb : '0;

   assign stats.hits   = hit_cnt;
   assign stats.misses = miss_cnt;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= CACHE_IDLE;
         done_q     <= 1'b0;
         hit_cnt    <= '0;
         miss_cnt   <= '0;
         line_valid <= '0;
      end else begin
         done_q <= 1'b0;
         case (state)
            CACHE_IDLE: begin
               // The master still holds valid while done_q is up
               if (fe_req.valid && !done_q) begin
                  state <= CACHE_LOOKUP;
               end
            end
            CACHE_LOOKUP: begin
               if (is_write) begin
                  state <= CACHE_WRITE;
               end else if (tag_hit) begin
                  state   <= CACHE_IDLE;
                  hit_cnt <= hit_cnt + 1'b1;
               end else begin
                  state    <= CACHE_REFILL;
                  miss_cnt <= miss_cnt + 1'b1;
               end
            end
            CACHE_REFILL: begin
               if (be_resp.ready) begin
                  line_valid[idx] <= 1'b1;
                  done_q          <= 1'b1;
                  state           <= CACHE_IDLE;
               end
            end
            CACHE_WRITE: begin
               if (be_resp.ready) begin
                  done_q <= 1'b1;
                  state  <= CACHE_IDLE;
               end
            end
            default: state <= CACHE_IDLE;
         endcase
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk) begin
      if ((state == CACHE_REFILL) && be_resp.ready) begin
         tag_arr[idx]  <= tag;
         data_arr[idx] <= be_resp.rdata;
      end
      // Write-through, the line is only patched when already present
      if ((state == CACHE_WRITE) && be_resp.ready && tag_hit) begin
         for (int b = 0; b < `EXT_MEM_DATA_W / 8; b++) begin
            if (fe_req.wstrb[b]) begin
               data_arr[idx][8*b +: 8] <= fe_req.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

/* ext_mem_pkg.sv */
`include "ext_mem_defs.svh"

package ext_mem_pkg;

   typedef logic [`EXT_MEM_DATA_W-1:0]     data_t;
   typedef logic [`EXT_MEM_ADDR_W-1:0]     addr_t;
   typedef logic [`EXT_MEM_MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [`EXT_MEM_DATA_W/8-1:0]   strb_t;
   typedef logic [`EXT_MEM_CNT_W-1:0]      cnt_t;

   // Native request, wstrb of zero is a read
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } mem_req_t;

   typedef struct packed {
      data_t rdata;
      logic  ready;
   } mem_resp_t;

   typedef struct packed {
      cnt_t hits;
      cnt_t misses;
   } cache_stats_t;

   // AXI4-Lite channels as seen from the master
   typedef struct packed {
      mem_addr_t awaddr;
      logic      awvalid;
      data_t     wdata;
      strb_t     wstrb;
      logic      wvalid;
      logic      bready;
      mem_addr_t araddr;
      logic      arvalid;
      logic      rready;
   } axi_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic [1:0] bresp;
      logic       bvalid;
      logic       arready;
      data_t      rdata;
      logic [1:0] rresp;
      logic       rvalid;
   } axi_resp_t;

   typedef enum logic [1:0] {
      CACHE_IDLE,
      CACHE_LOOKUP,
      CACHE_REFILL,
      CACHE_WRITE
   } cache_state_t;

   typedef enum logic [2:0] {
      BR_IDLE,
      BR_WRITE,
      BR_WRESP,
      BR_READ,
      BR_RDATA,
      BR_DONE
   } bridge_state_t;

endpackage

/* ext_mem_defs.svh */
`ifndef EXT_MEM_DEFS_SVH
`define EXT_MEM_DEFS_SVH

// One word on every bus
`define EXT_MEM_DATA_W 32

// Byte address on the native ports
`define EXT_MEM_ADDR_W 32

// Byte address towards external memory, upper native bits dropped
`define EXT_MEM_MEM_ADDR_W 16

// Index widths of the two caches
`define EXT_MEM_ICACHE_LINE_W 4
`define EXT_MEM_DCACHE_LINE_W 5

// Hit and miss counter width
`define EXT_MEM_CNT_W 16

`endif
